// File: source/alu.sv
module alu (
    input  cpu_pkg::opcode_t opcode,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    input  cpu_pkg::half_t   value,
    input  logic             high_low,
    output cpu_pkg::word_t   result,
    output logic             flag_out
);

    logic [32:0] sum;
    logic [32:0] difference;

    // bit 32 holds the carry of the sum and the borrow of the difference
    assign sum        = {1'b0, operand_a} + {1'b0, operand_b};
    assign difference = {1'b0, operand_a} - {1'b0, operand_b};

    always_comb
    begin
        result   = '0;
        flag_out = 1'b0;
        case (opcode)
            cpu_pkg::OP_ADD:
            begin
                result   = sum[31:0];
                flag_out = sum[32];
            end
            cpu_pkg::OP_SUB:
            begin
                result   = difference[31:0];
                flag_out = difference[32];
            end
            cpu_pkg::OP_AND:
            begin
                result   = operand_a & operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::OP_OR:
            begin
                result   = operand_a | operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::OP_XOR:
            begin
                result   = operand_a ^ operand_b;
                flag_out = (result == '0);
            end
            cpu_pkg::OP_LDI:
            begin
                result = high_low ? {value, 16'h0000} : {16'h0000, value};
            end
            cpu_pkg::OP_CMP:
            begin
                // unsigned a below b
                result   = difference[31:0];
                flag_out = (operand_a < operand_b);
            end
            default:
            begin
                result   = '0;
                flag_out = 1'b0;
            end
        endcase
    end

endmodule

// File: source/control_unit.sv
module control_unit (
    input  logic                clock,
    input  logic                rst,
    output cpu_pkg::word_t      araddr,
    output logic [2:0]          arprot,
    output logic                arvalid,
    input  logic                arready,
    input  cpu_pkg::word_t      rdata,
    input  logic                rvalid,
    output logic                rready,
    output cpu_pkg::word_t      awaddr,
    output logic                awvalid,
    input  logic                awready,
    output cpu_pkg::word_t      wdata,
    output logic                wvalid,
    input  logic                wready,
    input  logic                bvalid,
    output logic                bready,
    output logic                wr_en,
    output cpu_pkg::reg_index_t wr_index,
    output cpu_pkg::word_t      wr_data,
    output logic                wr_flag,
    output cpu_pkg::reg_index_t index_a,
    output cpu_pkg::reg_index_t index_b,
    input  cpu_pkg::word_t      operand_a,
    input  cpu_pkg::word_t      operand_b,
    input  logic                branch_flag,
    output cpu_pkg::opcode_t    opcode,
    output cpu_pkg::half_t      value,
    output logic                high_low,
    input  cpu_pkg::word_t      alu_result,
    input  logic                alu_flag
);

    cpu_pkg::cpu_state_t state;
    cpu_pkg::word_t      pc;
    cpu_pkg::word_t      instr;
    cpu_pkg::word_t      mem_addr;
    cpu_pkg::word_t      store_data;
    logic                alu_write;

    // instruction fields
    assign opcode   = instr[5:0];
    assign index_a  = instr[8:6];
    assign index_b  = instr[11:9];
    assign wr_index = instr[14:12];
    assign high_low = instr[15];
    assign value    = instr[31:16];

    // ADD through CMP write a register and its flag
    assign alu_write = (opcode <= cpu_pkg::OP_CMP);

    // a load writes on the read data handshake
    assign wr_en   = (state == cpu_pkg::EXECUTE && alu_write) ||
                     (state == cpu_pkg::LOAD_DATA && rvalid);
    assign wr_data = (state == cpu_pkg::LOAD_DATA) ? rdata : alu_result;
    assign wr_flag = (state == cpu_pkg::LOAD_DATA) ? (rdata == '0) : alu_flag;

    assign araddr = (state == cpu_pkg::LOAD_ADDR) ? mem_addr : pc;
    assign arprot = (state == cpu_pkg::LOAD_ADDR) ? 3'b000 : 3'b100;
    assign awaddr = mem_addr;
    assign wdata  = store_data;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= cpu_pkg::FETCH_ADDR;
            pc      <= '0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end
        else
        begin
            case (state)
                cpu_pkg::FETCH_ADDR:
                begin
                    // only the first fetch after reset raises arvalid here
                    if (!arvalid)
                        arvalid <= 1'b1;
                    else if (arready)
                    begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= cpu_pkg::FETCH_DATA;
                    end
                end
                cpu_pkg::FETCH_DATA:
                begin
                    if (rvalid)
                    begin
                        rready <= 1'b0;
                        state  <= cpu_pkg::EXECUTE;
                    end
                end
                cpu_pkg::EXECUTE:
                begin
                    if (opcode == cpu_pkg::OP_BRF && branch_flag)
                        pc <= cpu_pkg::word_t'({value, 2'b00});
                    else
                        pc <= pc + 32'd4;
                    if (opcode == cpu_pkg::OP_LOAD)
                    begin
                        arvalid <= 1'b1;
                        state   <= cpu_pkg::LOAD_ADDR;
                    end
                    else if (opcode == cpu_pkg::OP_STORE)
                    begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= cpu_pkg::STORE_REQ;
                    end
                    else
                    begin
                        arvalid <= 1'b1;
                        state   <= cpu_pkg::FETCH_ADDR;
                    end
                end
                cpu_pkg::LOAD_ADDR:
                begin
                    if (arready)
                    begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= cpu_pkg::LOAD_DATA;
                    end
                end
                cpu_pkg::LOAD_DATA:
                begin
                    if (rvalid)
                    begin
                        rready  <= 1'b0;
                        arvalid <= 1'b1;
                        state   <= cpu_pkg::FETCH_ADDR;
                    end
                end
                cpu_pkg::STORE_REQ:
                begin
                    // address and data complete independently
                    if (awready)
                        awvalid <= 1'b0;
                    if (wready)
                        wvalid <= 1'b0;
                    if ((!awvalid || awready) && (!wvalid || wready))
                    begin
                        bready <= 1'b1;
                        state  <= cpu_pkg::STORE_RESP;
                    end
                end
                cpu_pkg::STORE_RESP:
                begin
                    if (bvalid)
                    begin
                        bready  <= 1'b0;
                        arvalid <= 1'b1;
                        state   <= cpu_pkg::FETCH_ADDR;
                    end
                end
                default:
                    state <= cpu_pkg::FETCH_ADDR;
            endcase
        end
    end

    // memory address and store data are frozen during EXECUTE
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::FETCH_DATA && rvalid)
            instr <= rdata;
        if (state == cpu_pkg::EXECUTE)
        begin
            mem_addr   <= operand_a + cpu_pkg::word_t'(value);
            store_data <= operand_b;
        end
    end

endmodule

// File: source/cpu.sv
module cpu #(
    parameter int REG_COUNT = 8
) (
    input  logic           clock,
    input  logic           rst,
    output cpu_pkg::word_t araddr,
    output logic [2:0]     arprot,
    output logic           arvalid,
    input  logic           arready,
    input  cpu_pkg::word_t rdata,
    input  logic [1:0]     rresp,
    input  logic           rvalid,
    output logic           rready,
    output cpu_pkg::word_t awaddr,
    output logic [2:0]     awprot,
    output logic           awvalid,
    input  logic           awready,
    output cpu_pkg::word_t wdata,
    output logic [3:0]     wstrb,
    output logic           wvalid,
    input  logic           wready,
    input  logic [1:0]     bresp,
    input  logic           bvalid,
    output logic           bready
);

    logic                wr_en;
    cpu_pkg::reg_index_t wr_index;
    cpu_pkg::word_t      wr_data;
    logic                wr_flag;
    cpu_pkg::reg_index_t index_a;
    cpu_pkg::reg_index_t index_b;
    cpu_pkg::word_t      operand_a;
    cpu_pkg::word_t      operand_b;
    logic                branch_flag;
    cpu_pkg::opcode_t    opcode;
    cpu_pkg::half_t      value;
    logic                high_low;
    cpu_pkg::word_t      alu_result;
    logic                alu_flag;

    // full-word writes only, unprivileged data
    assign wstrb  = 4'b1111;
    assign awprot = 3'b000;
    // rresp and bresp are not checked, every response counts as OKAY

    regfile_if #(.REG_COUNT(REG_COUNT)) rf_bus ();

    control_unit control (
        .clock(clock), .rst(rst),
        .araddr(araddr), .arprot(arprot), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bvalid(bvalid), .bready(bready),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_flag(wr_flag),
        .index_a(index_a), .index_b(index_b),
        .operand_a(operand_a), .operand_b(operand_b), .branch_flag(branch_flag),
        .opcode(opcode), .value(value), .high_low(high_low),
        .alu_result(alu_result), .alu_flag(alu_flag)
    );

    alu alu_unit (
        .opcode(opcode), .operand_a(operand_a), .operand_b(operand_b),
        .value(value), .high_low(high_low),
        .result(alu_result), .flag_out(alu_flag)
    );

    write_decoder #(.REG_COUNT(REG_COUNT)) decoder (
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_flag(wr_flag),
        .bus(rf_bus.writer)
    );

    generate
        for (genvar i = 0; i < REG_COUNT; i++)
        begin : g_slice
            register_slice slice (
                .clock(clock),
                .rst(rst),
                .bus(rf_bus.slice),
                .index(cpu_pkg::reg_index_t'(i))
            );
        end
    endgenerate

    operand_select #(.REG_COUNT(REG_COUNT)) selector (
        .bus(rf_bus.reader),
        .index_a(index_a), .index_b(index_b),
        .operand_a(operand_a), .operand_b(operand_b), .branch_flag(branch_flag)
    );

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [2:0]  reg_index_t;
    typedef logic [5:0]  opcode_t;

    // every opcode above OP_BRF runs as a no-operation
    localparam opcode_t OP_ADD   = 6'd0;
    localparam opcode_t OP_SUB   = 6'd1;
    localparam opcode_t OP_AND   = 6'd2;
    localparam opcode_t OP_OR    = 6'd3;
    localparam opcode_t OP_XOR   = 6'd4;
    localparam opcode_t OP_LDI   = 6'd5;
    localparam opcode_t OP_CMP   = 6'd6;
    localparam opcode_t OP_STORE = 6'd7;
    localparam opcode_t OP_LOAD  = 6'd8;
    localparam opcode_t OP_BRF   = 6'd9;

    // fetch, execute, then an optional load or store
    typedef enum logic [2:0] {
        FETCH_ADDR,
        FETCH_DATA,
        EXECUTE,
        LOAD_ADDR,
        LOAD_DATA,
        STORE_REQ,
        STORE_RESP
    } cpu_state_t;

endpackage

// File: source/operand_select.sv
module operand_select #(
    parameter int REG_COUNT = 8
) (
    regfile_if.reader           bus,
    input  cpu_pkg::reg_index_t index_a,
    input  cpu_pkg::reg_index_t index_b,
    output cpu_pkg::word_t      operand_a,
    output cpu_pkg::word_t      operand_b,
    output logic                branch_flag
);

    // maps a 3-bit index onto the slices that exist
    function automatic int unsigned lane(input cpu_pkg::reg_index_t index);
        return index % REG_COUNT;
    endfunction

    assign operand_a = bus.q[lane(index_a)];
    assign operand_b = bus.q[lane(index_b)];

    // a branch tests the flag chosen by source index a
    assign branch_flag = bus.fq[lane(index_a)];

endmodule

// File: source/regfile_if.sv
interface regfile_if #(
    parameter int REG_COUNT = 8
);

    // write side, broadcast to every slice
    logic [REG_COUNT-1:0] we;
    cpu_pkg::word_t       wdata;
    logic                 wflag;

    // one lane per slice
    cpu_pkg::word_t       q [REG_COUNT];
    logic [REG_COUNT-1:0] fq;

    modport writer (output we, wdata, wflag);
    modport slice  (input we, wdata, wflag, output q, fq);
    modport reader (input q, fq);

endinterface

// File: source/register_slice.sv
module register_slice (
    input  logic                clock,
    input  logic                rst,
    regfile_if.slice            bus,
    input  cpu_pkg::reg_index_t index
);

    // the slice owns only lane index of q and fq
    always @(posedge clock)
    begin
        if (rst)
        begin
            bus.q[index]  <= '0;
            bus.fq[index] <= 1'b0;
        end
        else if (bus.we[index])
        begin
            bus.q[index]  <= bus.wdata;
            bus.fq[index] <= bus.wflag;
        end
    end

endmodule

// File: source/write_decoder.sv
module write_decoder #(
    parameter int REG_COUNT = 8
) (
    input  logic                wr_en,
    input  cpu_pkg::reg_index_t wr_index,
    input  cpu_pkg::word_t      wr_data,
    input  logic                wr_flag,
    regfile_if.writer           bus
);

    // one-hot strobe, upper indices wrap when REG_COUNT is below 8
    always_comb
    begin
        for (int i = 0; i < REG_COUNT; i++)
        begin
            bus.we[i] = wr_en && ((wr_index % REG_COUNT) == i);
        end
    end

    // data and flag go to all slices, only the strobed one takes them
    assign bus.wdata = wr_data;
    assign bus.wflag = wr_flag;

endmodule

// File: verification/clock_gen.sv
module clock_gen #(
    parameter int PERIOD = 10
) (
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever
            #(PERIOD / 2) clock = ~clock;
    end

endmodule

// File: verification/cpu_checker.sv
module cpu_checker (
    input logic                clock,
    input logic                rst,
    input cpu_pkg::word_t      araddr,
    input logic [2:0]          arprot,
    input logic                arvalid,
    input logic                arready,
    input logic                rready,
    input cpu_pkg::word_t      awaddr,
    input logic                awvalid,
    input logic                awready,
    input cpu_pkg::word_t      wdata,
    input logic                wvalid,
    input logic                wready,
    input logic                bready,
    input cpu_pkg::cpu_state_t state
);

    int failures = 0;

    // the cycle after any reset edge starts with every request low
    reset_idle: assert property (@(posedge clock)
        rst |=> !(arvalid || rready || awvalid || wvalid || bready))
        else
        begin
            failures++;
            $error("request output active after reset");
        end

    ar_hold: assert property (@(posedge clock) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arprot))
        else
        begin
            failures++;
            $error("read address channel changed before its handshake");
        end

    aw_hold: assert property (@(posedge clock) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else
        begin
            failures++;
            $error("write address channel changed before its handshake");
        end

    w_hold: assert property (@(posedge clock) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else
        begin
            failures++;
            $error("write data channel changed before its handshake");
        end

    // response readies belong to the waiting states only
    ready_state: assert property (@(posedge clock) disable iff (rst)
        (!rready || state inside {cpu_pkg::FETCH_DATA, cpu_pkg::LOAD_DATA}) &&
        (!bready || state == cpu_pkg::STORE_RESP))
        else
        begin
            failures++;
            $error("rready or bready raised outside its state");
        end

endmodule

// File: verification/cpu_monitor.sv
module cpu_monitor (
    input  logic           clock,
    input  logic           rst,
    input  cpu_pkg::word_t araddr,
    input  logic [2:0]     arprot,
    input  logic           arvalid,
    input  logic           arready,
    input  cpu_pkg::word_t rdata,
    input  logic           rvalid,
    input  logic           rready,
    input  cpu_pkg::word_t awaddr,
    input  logic [2:0]     awprot,
    input  logic           awvalid,
    input  logic           awready,
    input  cpu_pkg::word_t wdata,
    input  logic [3:0]     wstrb,
    input  logic           wvalid,
    input  logic           wready,
    input  logic           bvalid,
    input  logic           bready,
    output int             errors
);

    cpu_pkg::word_t regs [8];
    logic [7:0]     flags;
    cpu_pkg::word_t pc;
    cpu_pkg::word_t mem_addr;
    cpu_pkg::word_t store_data;
    logic [2:0]     load_dest;
    logic           load_next;
    logic           store_next;
    logic           read_busy;
    logic           prev_rst;
    int             error_count = 0;

    assign errors = error_count;

    task automatic compare_word(input string name, input cpu_pkg::word_t expected,
                                input cpu_pkg::word_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("monitor: %s at %0t", what, $time);
    endtask

    // reference model of one fetched instruction
    task automatic execute(input cpu_pkg::word_t instr);
        cpu_pkg::opcode_t op;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        cpu_pkg::half_t   v;
        cpu_pkg::word_t   r;
        logic             f;
        op = instr[5:0];
        a  = regs[instr[8:6]];
        b  = regs[instr[11:9]];
        v  = instr[31:16];
        f  = 1'b0;
        case (op)
            cpu_pkg::OP_ADD:
            begin
                r = a + b;
                // carry out when the sum wraps
                f = (r < a);
            end
            cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: {f, r} = {a < b, a - b};
            cpu_pkg::OP_AND: r = a & b;
            cpu_pkg::OP_OR: r = a | b;
            cpu_pkg::OP_XOR: r = a ^ b;
            cpu_pkg::OP_LDI: r = instr[15] ? ({16'h0000, v} << 16) : {16'h0000, v};
            default: r = '0;
        endcase
        if (op == cpu_pkg::OP_AND || op == cpu_pkg::OP_OR || op == cpu_pkg::OP_XOR)
            f = (r == '0);
        // ADD through CMP write the destination register and flag
        if (op <= cpu_pkg::OP_CMP)
        begin
            regs[instr[14:12]]  = r;
            flags[instr[14:12]] = f;
        end
        mem_addr   = a + {16'h0000, v};
        store_data = b;
        load_dest  = instr[14:12];
        load_next  = (op == cpu_pkg::OP_LOAD);
        store_next = (op == cpu_pkg::OP_STORE);
        if (op == cpu_pkg::OP_BRF && flags[instr[8:6]])
            pc = {14'd0, v, 2'b00};
        else
            pc = pc + 32'd4;
    endtask

    always @(posedge clock)
    begin
        if (rst)
        begin
            regs       = '{default: '0};
            flags      = '0;
            pc         = '0;
            load_next  = 1'b0;
            store_next = 1'b0;
            read_busy  = 1'b0;
        end
        else
        begin
            if (prev_rst && (arvalid || rready || awvalid || wvalid || bready))
                report_failure("a request was active on the first cycle after reset");
            if (read_busy && (arvalid || awvalid || wvalid))
                report_failure("a new request was issued while a read was outstanding");
            if ((awvalid || wvalid) && !store_next)
                report_failure("a write was issued without a STORE instruction");
            if (arvalid && arready)
            begin
                if (store_next)
                    report_failure("a read was issued before the STORE completed");
                else if (load_next)
                begin
                    compare_word("arprot", 32'h0, 32'(arprot));
                    compare_word("araddr", mem_addr, araddr);
                end
                else
                begin
                    compare_word("arprot", 32'h4, 32'(arprot));
                    compare_word("araddr", pc, araddr);
                end
                read_busy = 1'b1;
            end
            if (rvalid && rready)
            begin
                if (load_next)
                begin
                    // memory answers a data read with its address XOR a fixed mask
                    regs[load_dest]  = mem_addr ^ 32'h5a5a_0000;
                    flags[load_dest] = (regs[load_dest] == '0);
                    load_next        = 1'b0;
                end
                else
                    execute(rdata);
                read_busy = 1'b0;
            end
            if (awvalid && awready)
            begin
                compare_word("awaddr", mem_addr, awaddr);
                compare_word("awprot", 32'h0, 32'(awprot));
            end
            if (wvalid && wready)
            begin
                compare_word("wdata", store_data, wdata);
                compare_word("wstrb", 32'hf, 32'(wstrb));
            end
            if (bvalid && bready)
                store_next = 1'b0;
        end
        prev_rst = rst;
    end

endmodule

// File: verification/cpu_tb.sv
module cpu_tb;

    localparam int RUN_LENGTH = 400;
    localparam int TIMEOUT    = 50;

    logic           clock;
    logic           rst;
    cpu_pkg::word_t araddr;
    logic [2:0]     arprot;
    logic           arvalid;
    logic           arready;
    cpu_pkg::word_t rdata;
    logic           rvalid;
    logic           rready;
    cpu_pkg::word_t awaddr;
    logic [2:0]     awprot;
    logic           awvalid;
    logic           awready;
    cpu_pkg::word_t wdata;
    logic [3:0]     wstrb;
    logic           wvalid;
    logic           wready;
    logic           bvalid;
    logic           bready;
    logic [31:0]    seed;
    logic           hung;
    int             executed;
    int             monitor_errors;
    cpu_pkg::word_t instr;
    cpu_pkg::word_t load_word;

    clock_gen clock_source (.clock(clock));

    cpu UUT (.*, .rresp(2'b00), .bresp(2'b00));

    cpu_monitor monitor (.*, .errors(monitor_errors));

    bind cpu cpu_checker axi_checks (.*, .state(control.state));

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // upper LCG bits have the longer period
    function automatic int random_below(input int limit);
        seed = lcg_next(seed);
        return int'(seed[31:16]) % limit;
    endfunction

    function automatic logic request_level(input string name);
        case (name)
            "arvalid": return arvalid;
            "rready": return rready;
            "awvalid": return awvalid;
            default: return bready;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic pause_random();
        repeat (random_below(4))
            next_cycle();
    endtask

    task automatic wait_request(input string name);
        int cycles;
        cycles = 0;
        while (!request_level(name) && cycles < TIMEOUT)
        begin
            next_cycle();
            cycles++;
        end
        if (!request_level(name))
        begin
            $display("hang: %s stayed low for %0d cycles", name, TIMEOUT);
            hung = 1'b1;
        end
    endtask

    task automatic read_transfer(input logic fetch, output cpu_pkg::word_t word);
        cpu_pkg::word_t address;
        int             opcode;
        word = '0;
        wait_request("arvalid");
        if (hung)
            return;
        address = araddr;
        pause_random();
        arready = 1'b1;
        next_cycle();
        arready = 1'b0;
        wait_request("rready");
        if (hung)
            return;
        if (fetch)
        begin
            // opcodes 10 and 11 fall through as no-operations
            opcode = random_below(12);
            seed   = lcg_next(seed);
            word   = {seed[31:6], opcode[5:0]};
        end
        else
            word = address ^ 32'h5a5a_0000;
        pause_random();
        rdata  = word;
        rvalid = 1'b1;
        next_cycle();
        rvalid = 1'b0;
    endtask

    task automatic write_transfer();
        int aw_delay;
        int w_delay;
        int cycle;
        wait_request("awvalid");
        if (hung)
            return;
        aw_delay = random_below(4);
        w_delay  = random_below(4);
        // address and data each accepted on their own cycle
        for (cycle = 0; cycle <= aw_delay || cycle <= w_delay; cycle++)
        begin
            awready = (cycle == aw_delay);
            wready  = (cycle == w_delay);
            next_cycle();
        end
        awready = 1'b0;
        wready  = 1'b0;
        wait_request("bready");
        if (hung)
            return;
        pause_random();
        bvalid = 1'b1;
        next_cycle();
        bvalid = 1'b0;
    endtask

    initial
    begin
        seed     = 32'hc01f;
        hung     = 1'b0;
        executed = 0;
        rst      = 1'b1;
        arready  = 1'b0;
        rdata    = '0;
        rvalid   = 1'b0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        repeat (5)
            @(posedge clock);
        #1;
        rst = 1'b0;
        while (executed < RUN_LENGTH && !hung)
        begin
            read_transfer(1'b1, instr);
            if (!hung)
            begin
                executed++;
                if (instr[5:0] == cpu_pkg::OP_LOAD)
                    read_transfer(1'b0, load_word);
                else if (instr[5:0] == cpu_pkg::OP_STORE)
                    write_transfer();
            end
        end
        next_cycle();
        $display("instructions %0d, monitor errors %0d, assertion failures %0d, hangs %0d",
                 executed, monitor_errors, UUT.axi_checks.failures, hung);
        if (monitor_errors == 0 && UUT.axi_checks.failures == 0 && !hung)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: verilog.f
source/cpu_pkg.sv
source/regfile_if.sv
source/register_slice.sv
source/write_decoder.sv
source/operand_select.sv
source/alu.sv
source/control_unit.sv
source/cpu.sv
verification/clock_gen.sv
verification/cpu_checker.sv
verification/cpu_monitor.sv
verification/cpu_tb.sv
